// ==== island_pkg.sv ====
// Shared definitions for the safety island memory subsystem.
// Holds the address map, bus widths, region codes and SoC control
// register offsets. Modules refer to these by scoped names.

`default_nettype none

package island_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------

  // Byte address on the word bus
  typedef logic [31:0] addr_t;
  // One data word
  typedef logic [31:0] data_t;
  // One enable bit per byte of data_t
  typedef logic [3:0]  strb_t;
  // Boot mode code sampled from the pin
  typedef logic [1:0]  bootmode_t;

  // Region chosen by the address decoder
  typedef enum logic {
    REGION_MEM,
    REGION_PERIPH
  } region_e;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------

  // First word of bank 0, bank 1 follows directly
  localparam addr_t MemBaseAddr       = 32'h1000_0000;
  localparam addr_t PeriphBaseAddr    = 32'h2000_0000;
  // SoC control registers live at the start of the peripheral window
  localparam addr_t PeriphWindowBytes = 32'h0000_1000;

  localparam addr_t BootAddrDefault   = PeriphBaseAddr + 32'h0000_1080;

  // Returned for any access that hits the error target
  localparam data_t ErrorRdata        = 32'hBADC_AB1E;

  // --------------------------------------------------
  // SoC control register offsets
  // --------------------------------------------------

  localparam addr_t RegBootAddrOffs   = 32'h0000_0000;
  localparam addr_t RegFetchEnOffs    = 32'h0000_0004;
  localparam addr_t RegBootModeOffs   = 32'h0000_0008;

endpackage

`default_nettype wire

// ==== island_bus_if.sv ====
// Word bus with req/gnt/rvalid handshake.
// A request is accepted when req and gnt are high together; the response
// follows one cycle later with rvalid, rdata and err.

`timescale 1ns/1ps
`default_nettype none

interface island_bus_if;

  // Request side
  logic               req;
  logic               gnt;
  logic               we;
  island_pkg::strb_t  be;
  island_pkg::addr_t  addr;
  island_pkg::data_t  wdata;

  // Response side
  logic               rvalid;
  island_pkg::data_t  rdata;
  logic               err;

  modport initiator (
    output req, we, be, addr, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport target (
    input  req, we, be, addr, wdata,
    output gnt, rvalid, rdata, err
  );

  // Observes the response only
  modport monitor (
    input rvalid, rdata, err
  );

endinterface

`default_nettype wire

// ==== region_decoder.sv ====
// Splits requester accesses between the memory and peripheral regions.
// Purely combinational: the request goes out on the chosen bus only and
// the grant comes back from that same bus.

`timescale 1ns/1ps
`default_nettype none

module region_decoder #(
  parameter int unsigned BankNumBytes = 4096
) (
  input  logic                   req_i,
  input  logic                   we_i,
  input  island_pkg::strb_t      be_i,
  input  island_pkg::addr_t      addr_i,
  input  island_pkg::data_t      wdata_i,
  output logic                   gnt_o,
  island_bus_if.initiator        mem_bus,
  island_bus_if.initiator        periph_bus,
  output logic                   accept_o,
  output island_pkg::region_e    region_o
);

  // End of bank 1, exclusive
  localparam island_pkg::addr_t MemEndAddr =
    island_pkg::MemBaseAddr + island_pkg::addr_t'(2 * BankNumBytes);

  island_pkg::region_e region;

  // Everything outside the two banks belongs to the peripheral side
  assign region = ((addr_i >= island_pkg::MemBaseAddr) && (addr_i < MemEndAddr)) ?
                  island_pkg::REGION_MEM : island_pkg::REGION_PERIPH;

  assign mem_bus.req      = req_i && (region == island_pkg::REGION_MEM);
  assign periph_bus.req   = req_i && (region == island_pkg::REGION_PERIPH);

  // Payload fields go to both buses
  assign mem_bus.we       = we_i;
  assign mem_bus.be       = be_i;
  assign mem_bus.addr     = addr_i;
  assign mem_bus.wdata    = wdata_i;
  assign periph_bus.we    = we_i;
  assign periph_bus.be    = be_i;
  assign periph_bus.addr  = addr_i;
  assign periph_bus.wdata = wdata_i;

  assign gnt_o    = (region == island_pkg::REGION_MEM) ? mem_bus.gnt : periph_bus.gnt;
  assign accept_o = req_i && gnt_o;
  assign region_o = region;

endmodule

`default_nettype wire

// ==== sram_banks.sv ====
// Two byte-writable SRAM banks behind a single bus target.
// The address bit just above the bank offset picks the bank; reads return
// data one cycle after acceptance. BankNumBytes must be a power of two.

`timescale 1ns/1ps
`default_nettype none

module sram_banks #(
  parameter int unsigned BankNumBytes = 4096
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  island_bus_if.target bus
);

  localparam int unsigned BankNumWords = BankNumBytes / 4;
  localparam int unsigned OffsBits     = $clog2(BankNumBytes);
  localparam int unsigned WordIdxBits  = OffsBits - 2;

  typedef logic [WordIdxBits-1:0] word_idx_t;

  // Both banks as one array, first index is the bank
  island_pkg::data_t mem_q [2][BankNumWords];

  word_idx_t          word_idx;
  logic               bank_sel;
  island_pkg::data_t  rdata_q;
  logic               rvalid_q;

  assign word_idx = bus.addr[OffsBits-1:2];
  assign bank_sel = bus.addr[OffsBits];

  // Always ready
  assign bus.gnt = bus.req;

  // --------------------------------------------------
  // Storage and read port
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int i = 0; i < 4; i++) begin
          if (bus.be[i]) begin
            mem_q[bank_sel][word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
        // Writes answer with zero data
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[bank_sel][word_idx];
      end
    end
  end

  // --------------------------------------------------
  // Response valid
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

`default_nettype wire

// ==== periph_block.sv ====
// SoC control registers and the error target behind one bus target.
// Drives the boot address and fetch enable of the island; fetch enable
// can be overridden from a pin. Addresses outside the control window
// hit the error target, which answers with an error and changes nothing.

`timescale 1ns/1ps
`default_nettype none

module periph_block (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  island_bus_if.target          bus,
  input  island_pkg::bootmode_t bootmode_i,
  input  logic                  fetch_enable_sel_i,
  input  logic                  fetch_enable_i,
  output island_pkg::addr_t     boot_addr_o,
  output logic                  fetch_enable_o
);

  island_pkg::addr_t  offs;
  island_pkg::addr_t  reg_offs;
  logic               in_ctrl;

  logic               boot_addr_sel;
  logic               fetch_en_sel;
  island_pkg::data_t  rdata_d;
  logic               err_d;

  island_pkg::addr_t  boot_addr_q;
  logic               fetch_en_q;
  island_pkg::data_t  rdata_q;
  logic               err_q;
  logic               rvalid_q;

  // Every access is taken at once
  assign bus.gnt = bus.req;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------

  assign offs     = bus.addr - island_pkg::PeriphBaseAddr;
  // Byte lanes within a word do not matter for register selection
  assign reg_offs = {offs[31:2], 2'b00};
  assign in_ctrl  = (bus.addr >= island_pkg::PeriphBaseAddr) &&
                    (offs < island_pkg::PeriphWindowBytes);

  always_comb begin
    boot_addr_sel = 1'b0;
    fetch_en_sel  = 1'b0;
    rdata_d       = '0;
    err_d         = 1'b0;
    if (!in_ctrl) begin
      // Error target, same answer for reads and writes
      rdata_d = island_pkg::ErrorRdata;
      err_d   = 1'b1;
    end else begin
      case (reg_offs)
        island_pkg::RegBootAddrOffs: begin
          boot_addr_sel = 1'b1;
          if (!bus.we) rdata_d = boot_addr_q;
        end
        island_pkg::RegFetchEnOffs: begin
          fetch_en_sel = 1'b1;
          if (!bus.we) rdata_d = {31'b0, fetch_en_q};
        end
        island_pkg::RegBootModeOffs: begin
          // Read-only, writes are dropped without error
          if (!bus.we) rdata_d = island_pkg::data_t'(bootmode_i);
        end
        default: begin
          err_d = 1'b1;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Control registers
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_addr_q <= island_pkg::BootAddrDefault;
      fetch_en_q  <= 1'b0;
    end else if (bus.req && bus.we) begin
      if (boot_addr_sel) begin
        for (int i = 0; i < 4; i++) begin
          if (bus.be[i]) boot_addr_q[8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
      // Only bit 0 is kept
      if (fetch_en_sel && bus.be[0]) begin
        fetch_en_q <= bus.wdata[0];
      end
    end
  end

  // --------------------------------------------------
  // Response
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;

  // Pin override of the fetch enable register
  assign fetch_enable_o = fetch_enable_sel_i ? fetch_enable_i : fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

// ==== resp_combiner.sv ====
// Merges the responses of both regions onto the requester port.
// Remembers which region took the request in each cycle and passes that
// region's response through in the following cycle.

`timescale 1ns/1ps
`default_nettype none

module resp_combiner (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                accept_i,
  input  island_pkg::region_e region_i,
  island_bus_if.monitor       mem_bus,
  island_bus_if.monitor       periph_bus,
  output logic                rvalid_o,
  output island_pkg::data_t   rdata_o,
  output logic                err_o
);

  logic                pending_q;
  island_pkg::region_e region_q;
  logic                sel_mem;

  // One response in flight at most
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      region_q  <= island_pkg::REGION_MEM;
    end else begin
      pending_q <= accept_i;
      if (accept_i) region_q <= region_i;
    end
  end

  assign sel_mem = (region_q == island_pkg::REGION_MEM);

  assign rvalid_o = pending_q && (sel_mem ? mem_bus.rvalid : periph_bus.rvalid);
  assign rdata_o  = sel_mem ? mem_bus.rdata : periph_bus.rdata;
  assign err_o    = sel_mem ? mem_bus.err   : periph_bus.err;

endmodule

`default_nettype wire

// ==== island_top.sv ====
// Top level of the safety island memory subsystem.
// One requester port reaches two SRAM banks and the peripheral region
// (SoC control and error target); boot address and fetch enable come out
// as plain ports for the core.

`timescale 1ns/1ps
`default_nettype none

module island_top #(
  parameter int unsigned BankNumBytes = 4096
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Requester port
  input  logic                  req_i,
  input  logic                  we_i,
  input  island_pkg::strb_t     be_i,
  input  island_pkg::addr_t     addr_i,
  input  island_pkg::data_t     wdata_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output island_pkg::data_t     rdata_o,
  output logic                  err_o,

  // Boot control
  input  island_pkg::bootmode_t bootmode_i,
  input  logic                  fetch_enable_sel_i,
  input  logic                  fetch_enable_i,
  output island_pkg::addr_t     boot_addr_o,
  output logic                  fetch_enable_o
);

  logic                accept;
  island_pkg::region_e region;

  island_bus_if mem_bus ();
  island_bus_if periph_bus ();

  region_decoder #(
    .BankNumBytes ( BankNumBytes )
  ) i_region_decoder (
    .req_i      ( req_i      ),
    .we_i       ( we_i       ),
    .be_i       ( be_i       ),
    .addr_i     ( addr_i     ),
    .wdata_i    ( wdata_i    ),
    .gnt_o      ( gnt_o      ),
    .mem_bus    ( mem_bus    ),
    .periph_bus ( periph_bus ),
    .accept_o   ( accept     ),
    .region_o   ( region     )
  );

  sram_banks #(
    .BankNumBytes ( BankNumBytes )
  ) i_sram_banks (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .bus    ( mem_bus )
  );

  periph_block i_periph_block (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .bus                ( periph_bus         ),
    .bootmode_i         ( bootmode_i         ),
    .fetch_enable_sel_i ( fetch_enable_sel_i ),
    .fetch_enable_i     ( fetch_enable_i     ),
    .boot_addr_o        ( boot_addr_o        ),
    .fetch_enable_o     ( fetch_enable_o     )
  );

  resp_combiner i_resp_combiner (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .accept_i   ( accept     ),
    .region_i   ( region     ),
    .mem_bus    ( mem_bus    ),
    .periph_bus ( periph_bus ),
    .rvalid_o   ( rvalid_o   ),
    .rdata_o    ( rdata_o    ),
    .err_o      ( err_o      )
  );

endmodule

`default_nettype wire

// ==== tb_island_top.sv ====
// Self-checking testbench for the island top level.
// Drives random requests from an LFSR, keeps a model of both banks and the
// control registers, and checks every response and boot control output.

`timescale 1ns/1ps
`default_nettype none

module tb_island_top;

  localparam int unsigned BankNumBytes = 4096;
  localparam int unsigned BankWords    = BankNumBytes / 4;
  // Words per bank that the tests touch
  localparam int unsigned UsedWords    = 32;
  localparam int unsigned MemReqs      = 300;
  localparam int unsigned RegReqs      = 20;
  localparam int unsigned MiscReqs     = 30;
  // Preload and readback of both banks plus three single register reads
  localparam int unsigned TotalReqs    = 4 * UsedWords + MemReqs + 2 * RegReqs +
                                         2 * MiscReqs + 3;
  localparam int unsigned CycleLimit   = 2 * TotalReqs + 100;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_i;
  logic                  we_i;
  island_pkg::strb_t     be_i;
  island_pkg::addr_t     addr_i;
  island_pkg::data_t     wdata_i;
  island_pkg::bootmode_t bootmode_i;
  logic                  fetch_enable_sel_i;
  logic                  fetch_enable_i;
  logic                  gnt_o;
  logic                  rvalid_o;
  island_pkg::data_t     rdata_o;
  logic                  err_o;
  island_pkg::addr_t     boot_addr_o;
  logic                  fetch_enable_o;

  // Reference model state
  island_pkg::data_t     mem_model [island_pkg::addr_t];
  island_pkg::addr_t     boot_addr_model;
  logic                  fetch_en_model;
  island_pkg::data_t     exp_rdata_q [$];
  logic                  exp_err_q [$];
  logic                  accepted_q;

  logic [31:0]           lfsr;
  int unsigned           cycles;
  int unsigned           errors;
  int unsigned           tests_passed;
  int unsigned           tests_failed;

  island_top DUT (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .req_i              ( req_i              ),
    .we_i               ( we_i               ),
    .be_i               ( be_i               ),
    .addr_i             ( addr_i             ),
    .wdata_i            ( wdata_i            ),
    .gnt_o              ( gnt_o              ),
    .rvalid_o           ( rvalid_o           ),
    .rdata_o            ( rdata_o            ),
    .err_o              ( err_o              ),
    .bootmode_i         ( bootmode_i         ),
    .fetch_enable_sel_i ( fetch_enable_sel_i ),
    .fetch_enable_i     ( fetch_enable_i     ),
    .boot_addr_o        ( boot_addr_o        ),
    .fetch_enable_o     ( fetch_enable_o     )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic island_pkg::data_t merge_bytes(input island_pkg::data_t old_w,
                                                    input island_pkg::data_t new_w,
                                                    input island_pkg::strb_t be);
    island_pkg::data_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  // Word k of a bank spread over the whole word index range
  function automatic island_pkg::addr_t mem_addr(input logic bank, input logic [4:0] k);
    return island_pkg::MemBaseAddr + bank * BankNumBytes +
           ((k * (BankWords / UsedWords + 1)) % BankWords) * 4;
  endfunction

  task automatic check_data(input string name, input island_pkg::data_t act,
                            input island_pkg::data_t exp);
    if (act !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic check_err(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input island_pkg::addr_t act,
                            input island_pkg::addr_t exp);
    if (act !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, act, exp);
      errors++;
    end
  endtask

  // Applies one accepted access to the model and queues its response
  task automatic model_access();
    island_pkg::addr_t waddr;
    island_pkg::addr_t offs;
    island_pkg::data_t rdata;
    logic              err;
    waddr = {addr_i[31:2], 2'b00};
    offs  = waddr - island_pkg::PeriphBaseAddr;
    rdata = '0;
    err   = 1'b0;
    if (waddr >= island_pkg::MemBaseAddr &&
        waddr < island_pkg::MemBaseAddr + 2 * BankNumBytes) begin
      if (we_i) begin
        mem_model[waddr] = merge_bytes(mem_model.exists(waddr) ? mem_model[waddr] : '0,
                                       wdata_i, be_i);
      end else begin
        rdata = mem_model[waddr];
      end
    end else if (waddr >= island_pkg::PeriphBaseAddr &&
                 offs < island_pkg::PeriphWindowBytes) begin
      case (offs)
        island_pkg::RegBootAddrOffs: begin
          if (we_i) boot_addr_model = merge_bytes(boot_addr_model, wdata_i, be_i);
          else rdata = boot_addr_model;
        end
        island_pkg::RegFetchEnOffs: begin
          if (we_i && be_i[0]) fetch_en_model = wdata_i[0];
          else if (!we_i) rdata = {31'b0, fetch_en_model};
        end
        island_pkg::RegBootModeOffs: begin
          if (!we_i) rdata = island_pkg::data_t'(bootmode_i);
        end
        default: err = 1'b1;
      endcase
    end else begin
      // Error target
      rdata = island_pkg::ErrorRdata;
      err   = 1'b1;
    end
    exp_rdata_q.push_back(rdata);
    exp_err_q.push_back(err);
  endtask

  task automatic issue(input logic we, input island_pkg::strb_t be,
                       input island_pkg::addr_t addr, input island_pkg::data_t wdata);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    be_i    <= be;
    addr_i  <= addr;
    wdata_i <= wdata;
  endtask

  task automatic idle();
    @(posedge clk_i);
    req_i <= 1'b0;
  endtask

  // Drains the last response, then reports the test
  task automatic end_test(input string name, input int unsigned errs_at_start);
    idle();
    repeat (2) @(posedge clk_i);
    if (errors == errs_at_start) begin
      tests_passed++;
      $display("PASS: %s", name);
    end else begin
      tests_failed++;
      $display("FAIL: %s (%0d errors)", name, errors - errs_at_start);
    end
  endtask

  // --------------------------------------------------
  // Response and output monitor
  // --------------------------------------------------

  // Sampled mid-cycle away from the driving edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (rvalid_o) begin
        if (exp_rdata_q.size() == 0) begin
          $display("ERROR: rvalid_o came without an accepted request");
          errors++;
        end else begin
          check_data("rdata_o", rdata_o, exp_rdata_q.pop_front());
          check_err("err_o", err_o, exp_err_q.pop_front());
        end
      end else if (accepted_q) begin
        $display("ERROR: no rvalid_o one cycle after an accepted request");
        errors++;
        void'(exp_rdata_q.pop_front());
        void'(exp_err_q.pop_front());
      end
      check_addr("boot_addr_o", boot_addr_o, boot_addr_model);
      check_bit("fetch_enable_o", fetch_enable_o,
                fetch_enable_sel_i ? fetch_enable_i : fetch_en_model);
      check_bit("gnt_o", gnt_o, req_i);
      accepted_q = req_i && gnt_o;
      if (accepted_q) model_access();
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the run did not end within %0d cycles", CycleLimit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    int unsigned       errs;
    logic              we;
    island_pkg::strb_t be;
    island_pkg::addr_t addr;
    island_pkg::data_t wdata;
    lfsr               = 32'h6f;
    cycles             = 0;
    errors             = 0;
    tests_passed       = 0;
    tests_failed       = 0;
    accepted_q         = 1'b0;
    boot_addr_model    = island_pkg::BootAddrDefault;
    fetch_en_model     = 1'b0;
    rst_ni             = 1'b0;
    req_i              = 1'b0;
    we_i               = 1'b0;
    be_i               = '0;
    addr_i             = '0;
    wdata_i            = '0;
    bootmode_i         = '0;
    fetch_enable_sel_i = 1'b0;
    fetch_enable_i     = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    errs = errors;
    @(negedge clk_i);
    check_addr("boot_addr_o", boot_addr_o, island_pkg::BootAddrDefault);
    issue(1'b0, 4'hF, island_pkg::PeriphBaseAddr + island_pkg::RegBootAddrOffs, '0);
    end_test("reset values", errs);

    // Preload with a pattern of the full address, then random traffic
    errs = errors;
    for (int b = 0; b < 2; b++) begin
      for (int k = 0; k < UsedWords; k++) begin
        addr = mem_addr(1'(b), 5'(k));
        issue(1'b1, 4'hF, addr, addr ^ 32'h5A5A_C3C3);
      end
    end
    for (int n = 0; n < MemReqs; n++) begin
      we    = 1'(rand_bits(1));
      be    = 4'(rand_bits(4));
      addr  = mem_addr(1'(rand_bits(1)), 5'(rand_bits(5)));
      wdata = rand_bits(32);
      issue(we, be, addr, wdata);
      if (rand_bits(2) == 0) idle();
    end
    end_test("memory traffic", errs);

    errs = errors;
    for (int n = 0; n < RegReqs; n++) begin
      we    = 1'(rand_bits(1));
      be    = 4'(rand_bits(4));
      wdata = rand_bits(32);
      issue(we, be, island_pkg::PeriphBaseAddr + island_pkg::RegBootAddrOffs, wdata);
    end
    end_test("boot address register", errs);

    errs = errors;
    for (int n = 0; n < RegReqs; n++) begin
      we    = 1'(rand_bits(1));
      be    = 4'(rand_bits(4));
      wdata = rand_bits(32);
      issue(we, be, island_pkg::PeriphBaseAddr + island_pkg::RegFetchEnOffs, wdata);
      fetch_enable_sel_i <= 1'(rand_bits(1));
      fetch_enable_i     <= 1'(rand_bits(1));
    end
    end_test("fetch enable", errs);

    errs = errors;
    for (int n = 0; n < MiscReqs; n++) begin
      if (rand_bits(1)) begin
        addr = island_pkg::PeriphBaseAddr + island_pkg::RegBootModeOffs;
      end else begin
        addr = island_pkg::PeriphBaseAddr + (rand_bits(10) << 2);
        if (addr - island_pkg::PeriphBaseAddr < 32'hC) addr = addr + 32'hC;
      end
      we    = 1'(rand_bits(1));
      be    = 4'(rand_bits(4));
      wdata = rand_bits(32);
      issue(we, be, addr, wdata);
      bootmode_i <= 2'(rand_bits(2));
    end
    end_test("boot mode and unmapped offsets", errs);

    errs = errors;
    for (int n = 0; n < MiscReqs; n++) begin
      addr = rand_bits(30) << 2;
      // Move out of both windows
      if ((addr >= island_pkg::MemBaseAddr &&
           addr < island_pkg::MemBaseAddr + 2 * BankNumBytes) ||
          (addr >= island_pkg::PeriphBaseAddr &&
           addr < island_pkg::PeriphBaseAddr + island_pkg::PeriphWindowBytes)) begin
        addr = addr ^ 32'h8000_0000;
      end
      we    = 1'(rand_bits(1));
      be    = 4'(rand_bits(4));
      wdata = rand_bits(32);
      issue(we, be, addr, wdata);
    end
    for (int b = 0; b < 2; b++) begin
      for (int k = 0; k < UsedWords; k++) begin
        issue(1'b0, 4'hF, mem_addr(1'(b), 5'(k)), '0);
      end
    end
    issue(1'b0, 4'hF, island_pkg::PeriphBaseAddr + island_pkg::RegBootAddrOffs, '0);
    issue(1'b0, 4'hF, island_pkg::PeriphBaseAddr + island_pkg::RegFetchEnOffs, '0);
    end_test("error target", errs);

    $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
island_pkg.sv
island_bus_if.sv
region_decoder.sv
sram_banks.sv
periph_block.sv
resp_combiner.sv
island_top.sv
tb_island_top.sv

// ==== Bender.yml ====
package:
  name: island

sources:
  - island_pkg.sv
  - island_bus_if.sv
  - region_decoder.sv
  - sram_banks.sv
  - periph_block.sv
  - resp_combiner.sv
  - island_top.sv
  - target: test
    files:
      - tb_island_top.sv
